/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_qspi_xip
FILELIST  := src.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from grep, so a missing pass line fails the target
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/qspi_seq.sv */
`timescale 1ns/1ns
`include "xip_defines.svh"

module qspi_seq
	import xip_pkg::*;
(
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  xip_state_e                state,
	input  logic [7:0]                step,
	input  xip_addr_u                 fetch_addr,
	input  logic [3:0]                fdi,
	output logic [3:0]                fdo,
	output logic [3:0]                fdoe,
	output logic                      fcen,
	output logic                      fsclk,
	output logic [`XIP_LINE_BITS-1:0] line_data
);
	// Quad I/O fast read
	localparam logic [7:0] cmd_qread = 8'hEB;

	logic [3:0] nxt_fdo;
	logic [3:0] nxt_fdoe;
	logic       nxt_fcen;
	logic       nxt_clken;
	logic       clken;
	logic [2:0] cmd_bit;
	logic [2:0] addr_nib;
	logic [3:0] cap_idx;
	logic [5:0] cap_pos;

	assign cmd_bit  = 3'(step - (`XIP_INIT_FIRST + 8'd2));
	assign addr_nib = 3'(step - `XIP_RUN_FIRST);

	always_comb
	begin
		nxt_fcen  = 1'b1;
		nxt_clken = 1'b0;
		nxt_fdoe  = `XIP_FDOE_IDLE;
		nxt_fdo   = `XIP_FDO_IDLE;
		if (state == st_init)
		begin
			if (step == `XIP_INIT_FIRST + 8'd1)
				nxt_fcen = 1'b0;
			else if (step >= `XIP_INIT_FIRST + 8'd2 && step <= `XIP_INIT_FIRST + 8'd9)
			begin
				// Command goes out serially on IO0, MSB first
				nxt_fcen  = 1'b0;
				nxt_clken = 1'b1;
				nxt_fdo   = {3'b111, cmd_qread[3'd7 - cmd_bit]};
			end
			else if (step >= `XIP_INIT_FIRST + 8'd10 && step <= `XIP_INIT_FIRST + 8'd17)
			begin
				// Dummy address zero, then the mode byte
				nxt_fcen  = 1'b0;
				nxt_clken = 1'b1;
				nxt_fdoe  = 4'b1111;
				if (step == `XIP_INIT_FIRST + 8'd16)
					nxt_fdo = `XIP_MODE_HI;
				else if (step == `XIP_INIT_FIRST + 8'd17)
					nxt_fdo = `XIP_MODE_LO;
				else
					nxt_fdo = 4'h0;
			end
			else if (step >= `XIP_INIT_FIRST + 8'd18 && step < `XIP_INIT_LAST)
			begin
				nxt_fcen  = 1'b0;
				nxt_clken = 1'b1;
				nxt_fdoe  = 4'b0000;
				nxt_fdo   = 4'h0;
			end
		end
		else if (state == st_run)
		begin
			if (step >= `XIP_RUN_FIRST && step <= `XIP_RUN_FIRST + 8'd7)
			begin
				nxt_fcen  = 1'b0;
				nxt_clken = 1'b1;
				nxt_fdoe  = 4'b1111;
				if (step == `XIP_RUN_FIRST + 8'd6)
					nxt_fdo = `XIP_MODE_HI;
				else if (step == `XIP_RUN_FIRST + 8'd7)
					nxt_fdo = `XIP_MODE_LO;
				else
					nxt_fdo = fetch_addr.flat[4 * (5 - addr_nib) +: 4];
			end
			else if (step > `XIP_RUN_FIRST + 8'd7 && step < `XIP_DATA_LAST)
			begin
				// Dummy nibbles and then the line, pins released to the flash
				nxt_fcen  = 1'b0;
				nxt_clken = 1'b1;
				nxt_fdoe  = 4'b0000;
				nxt_fdo   = 4'h0;
			end
		end
	end

	always_ff @(negedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			fdo   <= 4'b1111;
			fdoe  <= 4'b0000;
			fcen  <= 1'b1;
			clken <= 1'b0;
		end
		else
		begin
			fdo   <= nxt_fdo;
			fdoe  <= nxt_fdoe;
			fcen  <= nxt_fcen;
			clken <= nxt_clken;
		end
	end

	assign fsclk = clken & HCLK;

	// High nibble of each byte first, bytes in ascending order
	assign cap_idx = 4'(step - `XIP_DATA_FIRST);
	assign cap_pos = {cap_idx[3:1], ~cap_idx[0], 2'b00};

	always_ff @(negedge HCLK)
	begin
		if (state == st_run && step >= `XIP_DATA_FIRST && step <= `XIP_DATA_LAST)
			line_data[cap_pos +: 4] <= fdi;
	end

endmodule

/* rtl/qspi_xip_top.sv */
`timescale 1ns/1ns
`include "xip_defines.svh"

module qspi_xip_top
	import xip_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic        HREADY,
	input  logic        HWRITE,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HADDR,
	output logic        HREADYOUT,
	output logic [31:0] HRDATA,
	input  logic [3:0]  fdi,
	output logic [3:0]  fdo,
	output logic [3:0]  fdoe,
	output logic        fsclk,
	output logic        fcen
);
	xip_addr_u                 aph_addr;
	xip_addr_u                 fetch_addr;
	xip_state_e                state;
	logic [7:0]                step;
	logic                      hit;
	logic                      fill;
	logic [`XIP_LINE_BITS-1:0] line_data;

	// Flash reads always start on a line boundary
	assign fetch_addr = {aph_addr.f.tag, aph_addr.f.idx, {`XIP_OFF_BITS{1'b0}}};

	xip_ctrl u_xip_ctrl (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSEL      (HSEL),
		.HREADY    (HREADY),
		.HTRANS    (HTRANS),
		.HADDR     (HADDR[23:0]),
		.hit       (hit),
		.aph_addr  (aph_addr),
		.state     (state),
		.step      (step),
		.fill      (fill),
		.HREADYOUT (HREADYOUT)
	);

	xip_cache u_xip_cache (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR[23:0]),
		.aph_addr  (aph_addr),
		.fill      (fill),
		.line_data (line_data),
		.hit       (hit),
		.HRDATA    (HRDATA)
	);

	qspi_seq u_qspi_seq (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.state      (state),
		.step       (step),
		.fetch_addr (fetch_addr),
		.fdi        (fdi),
		.fdo        (fdo),
		.fdoe       (fdoe),
		.fcen       (fcen),
		.fsclk      (fsclk),
		.line_data  (line_data)
	);

endmodule

/* rtl/xip_cache.sv */
`timescale 1ns/1ns
`include "xip_defines.svh"

module xip_cache
	import xip_pkg::*;
(
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  logic [23:0]               HADDR,
	input  xip_addr_u                 aph_addr,
	input  logic                      fill,
	input  logic [`XIP_LINE_BITS-1:0] line_data,
	output logic                      hit,
	output logic [31:0]               HRDATA
);
	logic [`XIP_LINE_BITS-1:0] data_mem [`XIP_LINES];
	logic [`XIP_TAG_BITS-1:0]  tag_mem  [`XIP_LINES];
	logic [`XIP_LINES-1:0]     valid;
	xip_addr_u                 live_addr;
	logic                      aph_hit;
	logic [`XIP_LINE_BITS-1:0] src_line;

	assign live_addr = HADDR;

	// Lookup for the address phase on the bus
	assign hit = valid[live_addr.f.idx] &&
		(tag_mem[live_addr.f.idx] == live_addr.f.tag);

	// Lookup for the registered data phase
	assign aph_hit = valid[aph_addr.f.idx] &&
		(tag_mem[aph_addr.f.idx] == aph_addr.f.tag);

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			valid <= '0;
		else if (fill)
			valid[aph_addr.f.idx] <= 1'b1;
	end

	always_ff @(posedge HCLK)
	begin
		if (fill)
		begin
			tag_mem[aph_addr.f.idx]  <= aph_addr.f.tag;
			data_mem[aph_addr.f.idx] <= line_data;
		end
	end

	// At the end of a miss the line comes straight from the sequencer
	assign src_line = aph_hit ? data_mem[aph_addr.f.idx] : line_data;

	assign HRDATA = aph_addr.f.off[2] ? src_line[63:32] : src_line[31:0];

endmodule

/* rtl/xip_ctrl.sv */
`timescale 1ns/1ns
`include "xip_defines.svh"

module xip_ctrl
	import xip_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic        HREADY,
	input  logic [1:0]  HTRANS,
	input  logic [23:0] HADDR,
	input  logic        hit,
	output xip_addr_u   aph_addr,
	output xip_state_e  state,
	output logic [7:0]  step,
	output logic        fill,
	output logic        HREADYOUT
);
	xip_state_e next_state;
	logic [7:0] next_step;
	logic       transfer;
	logic       pending;

	// NONSEQ or SEQ accepted this cycle
	assign transfer = HSEL & HREADY & HTRANS[1];

	assign fill = (state == st_run) && (step == `XIP_RUN_LAST);

	always_ff @(posedge HCLK)
	begin
		if (HSEL && HREADY)
			aph_addr <= HADDR;
	end

	// Transfers that arrive before the flash is ready wait here
	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			pending <= 1'b0;
		else if (transfer && (state == st_reset || state == st_init))
			pending <= 1'b1;
		else if (state == st_run)
			pending <= 1'b0;
	end

	always_comb
	begin
		case (state)
			st_reset: next_state = st_init;
			st_init:  next_state = (step == `XIP_INIT_LAST) ? st_rdy : st_init;
			st_rdy:   next_state = ((transfer && !hit) || pending) ? st_run : st_rdy;
			st_run:   next_state = (step == `XIP_RUN_LAST) ? st_rdy : st_run;
			default:  next_state = st_reset;
		endcase
	end

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			state <= st_reset;
		else
			state <= next_state;
	end

	// Step counter runs on the falling edge, half a cycle ahead of the pins
	always_comb
	begin
		case (state)
			st_reset: next_step = `XIP_INIT_FIRST;
			st_init:  next_step = step + 8'd1;
			st_rdy:   next_step = `XIP_RUN_FIRST;
			st_run:   next_step = step + 8'd1;
			default:  next_step = `XIP_INIT_FIRST;
		endcase
	end

	always_ff @(negedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			step <= `XIP_INIT_FIRST;
		else
			step <= next_step;
	end

	// Hits finish at once, misses stall until the line is written
	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
			HREADYOUT <= 1'b1;
		else if (transfer)
			HREADYOUT <= hit;
		else if (fill)
			HREADYOUT <= 1'b1;
	end

endmodule

/* rtl/xip_defines.svh */
`ifndef XIP_DEFINES_SVH
`define XIP_DEFINES_SVH

// Cache geometry, 32 lines of 8 bytes over a 16 MB flash window
`define XIP_LINES       32
`define XIP_OFF_BITS    3
`define XIP_IDX_BITS    5
`define XIP_TAG_BITS    16
`define XIP_LINE_BITS   64

// Start-up sequence steps
`define XIP_INIT_FIRST  8'd36
`define XIP_INIT_LAST   8'd58

// Fetch sequence steps
`define XIP_RUN_FIRST   8'd4
`define XIP_DATA_FIRST  8'd17
`define XIP_DATA_LAST   8'd32
`define XIP_RUN_LAST    8'd33

// Continuous read mode byte, sent as two nibbles
`define XIP_MODE_HI     4'hA
`define XIP_MODE_LO     4'h5

// Pins between accesses, IO1 released and WP/HOLD held high
`define XIP_FDOE_IDLE   4'b1101
`define XIP_FDO_IDLE    4'b1111

`endif

/* rtl/xip_pkg.sv */
`include "xip_defines.svh"

package xip_pkg;

	// Cache view of a flash byte address
	typedef struct packed {
		logic [`XIP_TAG_BITS-1:0] tag;
		logic [`XIP_IDX_BITS-1:0] idx;
		logic [`XIP_OFF_BITS-1:0] off;
	} xip_addr_s;

	// Same 24 bits, flat for the flash side
	typedef union packed {
		logic [`XIP_TAG_BITS+`XIP_IDX_BITS+`XIP_OFF_BITS-1:0] flat;
		xip_addr_s f;
	} xip_addr_u;

	typedef enum logic [1:0] {
		st_reset,
		st_init,
		st_rdy,
		st_run
	} xip_state_e;

endpackage

/* src.f */
+incdir+rtl
rtl/xip_pkg.sv
rtl/qspi_seq.sv
rtl/xip_cache.sv
rtl/xip_ctrl.sv
rtl/qspi_xip_top.sv
tb/flash_model.sv
tb/xip_checker.sv
tb/tb_qspi_xip.sv

/* tb/flash_model.sv */
`timescale 1ns/1ns

module flash_model
(
	input  logic       fsclk,
	input  logic       fcen,
	input  logic [3:0] fdo,
	input  logic [3:0] fdoe,
	output logic [3:0] fdi,
	output logic       init_done,
	output logic [7:0] init_cmd,
	output logic [7:0] init_mode,
	output int         fetch_count,
	output int         frame_errors
);
	int          edges = 0;
	int          fetch_cnt = 0;
	int          err_cnt = 0;
	logic        cont_mode = 1'b0;
	logic        started = 1'b0;
	logic        clash = 1'b0;
	logic [7:0]  cmd = 8'h00;
	logic [7:0]  mode = 8'h00;
	logic [7:0]  cmd_q = 8'h00;
	logic [7:0]  mode_q = 8'h00;
	logic [23:0] addr = 24'h0;
	logic [3:0]  fdi_q = 4'hF;

	assign fdi          = fdi_q;
	assign init_done    = started;
	assign init_cmd     = cmd_q;
	assign init_mode    = mode_q;
	assign fetch_count  = fetch_cnt;
	assign frame_errors = err_cnt;

	// Memory contents are computed from the address
	function automatic logic [7:0] byte_at(input logic [23:0] a);
		byte_at = a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	function automatic logic [3:0] nibble_at(input logic [23:0] base, input int k);
		logic [7:0] b;
		b = byte_at(base + 24'(k / 2));
		nibble_at = (k % 2 == 0) ? b[7:4] : b[3:0];
	endfunction

	task automatic flag_frame(input string msg);
		$display("flash model: %s", msg);
		err_cnt = err_cnt + 1;
	endtask

	task automatic close_frame;
		if (!cont_mode)
		begin
			cmd_q     = cmd;
			mode_q    = mode;
			started   = 1'b1;
			cont_mode = (cmd == 8'hEB) && (mode == 8'hA5);
			if (edges != 20)
				flag_frame($sformatf("start-up frame had %0d clocks instead of 20", edges));
		end
		else
		begin
			fetch_cnt = fetch_cnt + 1;
			if (edges != 28)
				flag_frame($sformatf("fetch frame had %0d clocks instead of 28", edges));
			if (mode != 8'hA5)
				flag_frame($sformatf("mode byte %h would end continuous read", mode));
			if (clash)
				flag_frame("controller drove the data pins during dummy or data clocks");
		end
		clash = 1'b0;
		edges = 0;
	endtask

	// Flash samples on the rising clock, frame ends when chip select rises
	always @(posedge fsclk or posedge fcen)
	begin
		if (fcen)
		begin
			if (edges > 0)
				close_frame();
		end
		else
		begin
			edges = edges + 1;
			if (!cont_mode)
			begin
				if (edges <= 8)
					cmd = {cmd[6:0], fdo[0]};
				else if (edges <= 14)
					addr = {addr[19:0], fdo};
				else if (edges <= 16)
					mode = {mode[3:0], fdo};
			end
			else if (edges <= 6)
				addr = {addr[19:0], fdo};
			else if (edges <= 8)
				mode = {mode[3:0], fdo};
			else if (fdoe != 4'b0000)
				clash = 1'b1;
		end
	end

	// Data leaves on the falling clock after the fourth dummy clock
	always @(negedge fsclk)
	begin
		if (!fcen && cont_mode && edges >= 12 && edges < 28)
			fdi_q <= nibble_at(addr, edges - 12);
		else
			fdi_q <= 4'hF;
	end

endmodule

/* tb/tb_qspi_xip.sv */
`timescale 1ns/1ns

module tb_qspi_xip;
	localparam int NUM_CONFLICT = 8;
	localparam int NUM_RANDOM   = 64;
	localparam int NUM_READS    = NUM_CONFLICT + NUM_RANDOM;
	localparam int CYCLE_LIMIT  = NUM_READS * 60 + 200;

	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic        HREADY;
	logic        HWRITE;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic [31:0] HADDR;
	logic        HREADYOUT;
	logic [31:0] HRDATA;
	logic [3:0]  fdi;
	logic [3:0]  fdo;
	logic [3:0]  fdoe;
	logic        fsclk;
	logic        fcen;
	logic        init_done;
	logic [7:0]  init_cmd;
	logic [7:0]  init_mode;
	logic        final_check;
	int          fetch_count;
	int          frame_errors;
	int          errors;
	int          reads;
	int          misses;
	int          cycles = 0;
	logic [31:0] addr_pool [8];

	// Single slave on the bus
	assign HREADY = HREADYOUT;

	qspi_xip_top u_qspi_xip_top (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSEL      (HSEL),
		.HREADY    (HREADY),
		.HWRITE    (HWRITE),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HADDR     (HADDR),
		.HREADYOUT (HREADYOUT),
		.HRDATA    (HRDATA),
		.fdi       (fdi),
		.fdo       (fdo),
		.fdoe      (fdoe),
		.fsclk     (fsclk),
		.fcen      (fcen)
	);

	flash_model u_flash_model (
		.fsclk        (fsclk),
		.fcen         (fcen),
		.fdo          (fdo),
		.fdoe         (fdoe),
		.fdi          (fdi),
		.init_done    (init_done),
		.init_cmd     (init_cmd),
		.init_mode    (init_mode),
		.fetch_count  (fetch_count),
		.frame_errors (frame_errors)
	);

	xip_checker u_xip_checker (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.HSEL        (HSEL),
		.HREADY      (HREADY),
		.HTRANS      (HTRANS),
		.HADDR       (HADDR),
		.HREADYOUT   (HREADYOUT),
		.HRDATA      (HRDATA),
		.fcen        (fcen),
		.init_done   (init_done),
		.init_cmd    (init_cmd),
		.init_mode   (init_mode),
		.fetch_count (fetch_count),
		.final_check (final_check),
		.errors      (errors),
		.reads       (reads),
		.misses      (misses)
	);

	initial
	begin
		HCLK = 1'b0;
		forever
		begin
			#5 HCLK = ~HCLK;
		end
	end

	always @(posedge HCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, a read never completed", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// Pool line plus a random word within the line
	function automatic logic [31:0] random_addr();
		logic [2:0] pick;
		logic       word;
		pick = 3'($urandom);
		word = 1'($urandom);
		random_addr = addr_pool[pick] | {29'd0, word, 2'b00};
	endfunction

	task automatic issue_read(input logic [31:0] addr, input int gap);
		HSEL   <= 1'b1;
		HTRANS <= 2'b10;
		HADDR  <= addr;
		// Address phase is held until the slave is ready
		do
		begin
			@(posedge HCLK);
		end
		while (!HREADY);
		HTRANS <= 2'b00;
		for (int i = 0; i < gap; i++)
		begin
			HSEL  <= 1'($urandom);
			HADDR <= random_addr();
			@(posedge HCLK);
		end
	endtask

	task automatic drain_bus;
		HTRANS <= 2'b00;
		do
		begin
			@(posedge HCLK);
		end
		while (!HREADY);
	endtask

	initial
	begin
		void'($urandom(32'hd753_2972));
		// Lines 0 and 1 share index 4, lines 3 and 7 share index 9
		addr_pool = '{32'h0000_0120, 32'h0001_2320, 32'h0000_0000, 32'h0000_0048,
			32'h00A5_5F80, 32'h00FF_FFF8, 32'h0003_4568, 32'h0000_1048};
		HRESETn     = 1'b0;
		HSEL        = 1'b0;
		HWRITE      = 1'b0;
		HTRANS      = 2'b00;
		HSIZE       = 3'b010;
		HADDR       = 32'h0;
		final_check = 1'b0;
		repeat (10) @(posedge HCLK);
		HRESETn <= 1'b1;
		@(posedge HCLK);
		// First conflict read lands while start-up is still running
		for (int i = 0; i < NUM_CONFLICT; i++)
			issue_read(addr_pool[i % 2], 0);
		for (int i = 0; i < NUM_RANDOM; i++)
			issue_read(random_addr(), int'($urandom % 3));
		drain_bus();
		final_check <= 1'b1;
		repeat (2) @(posedge HCLK);
		$display("Reads %0d, misses %0d, fetches %0d, checker errors %0d, flash errors %0d",
			reads, misses, fetch_count, errors, frame_errors);
		if (errors + frame_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* tb/xip_checker.sv */
`timescale 1ns/1ns
`include "xip_defines.svh"

module xip_checker
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic        HREADY,
	input  logic [1:0]  HTRANS,
	input  logic [31:0] HADDR,
	input  logic        HREADYOUT,
	input  logic [31:0] HRDATA,
	input  logic        fcen,
	input  logic        init_done,
	input  logic [7:0]  init_cmd,
	input  logic [7:0]  init_mode,
	input  int          fetch_count,
	input  logic        final_check,
	output int          errors,
	output int          reads,
	output int          misses
);
	logic [`XIP_TAG_BITS-1:0] tag_model [`XIP_LINES];
	logic [`XIP_LINES-1:0]    valid_model = '0;
	logic                     dph_active = 1'b0;
	logic                     dph_hit = 1'b0;
	logic [23:0]              dph_addr = 24'h0;
	logic                     init_seen = 1'b0;
	logic                     final_done = 1'b0;
	logic                     was_reset = 1'b0;
	int                       dph_cycles = 0;
	int                       err_cnt = 0;
	int                       read_cnt = 0;
	int                       miss_cnt = 0;

	assign errors = err_cnt;
	assign reads  = read_cnt;
	assign misses = miss_cnt;

	function automatic logic [7:0] byte_at(input logic [23:0] a);
		byte_at = a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	// Little endian word at the aligned address
	function automatic logic [31:0] word_at(input logic [23:0] a);
		logic [23:0] base;
		base = {a[23:2], 2'b00};
		word_at = {byte_at(base + 24'd3), byte_at(base + 24'd2),
			byte_at(base + 24'd1), byte_at(base)};
	endfunction

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s: expected %0h got %0h", name, expected, actual);
		err_cnt = err_cnt + 1;
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		err_cnt = err_cnt + 1;
	endtask

	task automatic start_read(input logic [23:0] a);
		logic [`XIP_IDX_BITS-1:0] idx;
		logic [`XIP_TAG_BITS-1:0] tag;
		idx = a[`XIP_OFF_BITS +: `XIP_IDX_BITS];
		tag = a[23 -: `XIP_TAG_BITS];
		dph_hit = valid_model[idx] && (tag_model[idx] == tag);
		if (!dph_hit)
			miss_cnt = miss_cnt + 1;
		// Either way the line is resident afterwards
		valid_model[idx] = 1'b1;
		tag_model[idx]   = tag;
		dph_addr   = a;
		dph_active = 1'b1;
		dph_cycles = 0;
		read_cnt   = read_cnt + 1;
	endtask

	task automatic finish_data_phase;
		if (dph_cycles == 0 && HREADYOUT !== dph_hit)
			report_value($sformatf("HREADYOUT at %h", dph_addr), 32'(dph_hit), 32'(HREADYOUT));
		dph_cycles = dph_cycles + 1;
		if (HREADYOUT)
		begin
			if (!init_done)
				report_error($sformatf("read at %h finished before start-up ended", dph_addr));
			if (HRDATA !== word_at(dph_addr))
				report_value($sformatf("HRDATA at %h", dph_addr), word_at(dph_addr), HRDATA);
			dph_active = 1'b0;
		end
	endtask

	always @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			was_reset  = 1'b1;
			dph_active = 1'b0;
		end
		else
		begin
			// First cycle out of reset still shows the reset values
			if (was_reset)
			begin
				was_reset = 1'b0;
				if (HREADYOUT !== 1'b1)
					report_value("HREADYOUT after reset", 32'h1, 32'(HREADYOUT));
				if (fcen !== 1'b1)
					report_value("fcen after reset", 32'h1, 32'(fcen));
			end
			if (init_done && !init_seen)
			begin
				init_seen = 1'b1;
				if (init_cmd !== 8'hEB)
					report_value("start-up command", 32'hEB, 32'(init_cmd));
				if (init_mode !== 8'hA5)
					report_value("start-up mode byte", 32'hA5, 32'(init_mode));
			end
			// Flash is only selected while a miss holds the bus
			if (init_done && !fcen && HREADYOUT)
				report_error("fcen was low while no fetch was outstanding");
			if (dph_active)
				finish_data_phase();
			if (HSEL && HREADY && HTRANS[1])
				start_read(HADDR[23:0]);
			if (final_check && !final_done)
			begin
				final_done = 1'b1;
				if (!init_done)
					report_error("start-up sequence never completed");
				if (fetch_count != miss_cnt)
					report_error($sformatf("flash saw %0d fetches but %0d misses were expected",
						fetch_count, miss_cnt));
			end
		end
	end

endmodule
